// ==== verilog.f ====
+incdir+tests
design/fetch_pkg.sv
design/target_buffer.sv
design/direction_predictor.sv
design/fetch_sequencer.sv
design/fetch_unit.sv
tests/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module fetch_tb -Mdir obj_dir -f verilog.f \
  && ./obj_dir/Vfetch_tb \
  || { echo "simulation run failed"; exit 1; }

// ==== tests/fetch_model.svh ====
// reference model of btb, pht, history and pc, plus the lfsr for memory data
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

  ////////////////////////////////////////
  // model state
  ////////////////////////////////////////
  logic        model_btb_valid  [btb_entries];
  btb_tag_t    model_btb_tag    [btb_entries];
  pc_t         model_btb_target [btb_entries];
  counter_t    model_pht        [pht_entries];
  pht_index_t  model_hist;                      // newest outcome in bit 0
  pc_t         model_pc;
  logic [15:0] lfsr_state;

  // fibonacci taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  // one lfsr step per data bit
  task automatic next_mem_word(output word_t word);
    for (int b = 0; b < word_width; b++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      word[b]    = lfsr_state[0];
    end
  endtask

  task automatic reset_model();
    model_pc   = '0;
    model_hist = '0;
    for (int i = 0; i < btb_entries; i++)
      model_btb_valid[i] = 1'b0;
    for (int i = 0; i < pht_entries; i++)
      model_pht[i] = counter_reset;   // weakly not taken
  endtask

  // prediction for one slot address, valid filled in by the caller
  function automatic fetch_slot_t predict_slot(pc_t pc, inst_t inst);
    fetch_slot_t s;
    btb_index_t  entry;
    logic        hit;
    entry        = pc[btb_index_bits+1:2];
    hit          = model_btb_valid[entry] && (model_btb_tag[entry] == pc[pc_width-1:6]);
    s.valid      = 1'b0;
    s.pc         = pc;
    s.inst       = inst;
    s.next_pc    = pc + 4;
    s.pht_index  = pc[hist_bits+1:2] ^ model_hist;  // gshare index
    s.pred_taken = hit && (model_pht[s.pht_index] >= counter_taken_min);
    s.pred_pc    = s.pred_taken ? model_btb_target[entry] : s.next_pc;
    return s;
  endfunction

  task automatic expect_slots(input word_t data, input logic busy,
                              output fetch_slot_t s0, output fetch_slot_t s1);
    pc_t base;
    base     = {model_pc[pc_width-1:3], 3'b000};
    s0       = predict_slot(base, data[inst_width-1:0]);
    s1       = predict_slot(base + 4, data[word_width-1:inst_width]);
    s0.valid = !model_pc[2] && !busy;                 // odd entry skips slot 0
    s1.valid = !(s0.valid && s0.pred_taken) && !busy;  // killed behind taken slot 0
  endtask

  // one rising edge, next pc first since it uses the old tables
  task automatic step_model(input resolve_t r, input logic busy,
                            input fetch_slot_t s0, input fetch_slot_t s1);
    if (r.valid && r.mispredict)
      model_pc = r.taken ? r.target : r.next_pc;
    else if (busy)
      model_pc = model_pc;  // hold
    else if (s0.valid && s0.pred_taken)
      model_pc = s0.pred_pc;
    else if (s1.valid && s1.pred_taken)
      model_pc = s1.pred_pc;
    else
      model_pc = {model_pc[pc_width-1:3], 3'b000} + 8;
    if (r.valid)
    begin
      if (r.taken)
      begin
        model_btb_valid[r.pc[btb_index_bits+1:2]]  = 1'b1;
        model_btb_tag[r.pc[btb_index_bits+1:2]]    = r.pc[pc_width-1:6];
        model_btb_target[r.pc[btb_index_bits+1:2]] = r.target;
      end
      if (r.taken && model_pht[r.pht_index] != 2'd3)
        model_pht[r.pht_index] = model_pht[r.pht_index] + 2'd1;
      else if (!r.taken && model_pht[r.pht_index] != 2'd0)
        model_pht[r.pht_index] = model_pht[r.pht_index] - 2'd1;
      model_hist = {model_hist[hist_bits-2:0], r.taken};
    end
  endtask

`endif

// ==== tests/fetch_tb.sv ====
// testbench for the fetch unit with stimulus table, reference model checks and run limit
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum logic [1:0] {res_none, res_taken_ok, res_taken_miss, res_not_taken_miss} res_kind_t;

  // one stimulus row with its name kept in a parallel queue
  typedef struct packed {
    logic       stall;
    logic       ready;
    res_kind_t  kind;
    pc_t        pc;      // branch being resolved
    pc_t        target;
    pht_index_t index;   // index handed back with the branch
  } row_t;

  logic        clock;
  logic        reset;
  logic        stall;
  logic        mem_ready;
  word_t       mem_data;
  resolve_t    resolve;
  pc_t         mem_addr;
  fetch_slot_t slot0;
  fetch_slot_t slot1;

  row_t  rows  [$];
  string names [$];
  int    cycles = 0;

`include "fetch_model.svh"

  fetch_unit dut0 (
    .clock     (clock),
    .reset     (reset),
    .stall     (stall),
    .mem_ready (mem_ready),
    .mem_data  (mem_data),
    .resolve   (resolve),
    .mem_addr  (mem_addr),
    .slot0     (slot0),
    .slot1     (slot1)
  );

  always #20 clock = ~clock;  // 40 ns period

  ////////////////////////////////////////
  // failure handling and compares
  ////////////////////////////////////////

  task automatic stop_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // table length plus reset and slack
  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles > rows.size() + 20)
    begin
      $display("timeout, the run went past %0d cycles without finishing", cycles);
      stop_with_failure();
    end
  end

  task automatic compare_addr(string test, pc_t expected, pc_t actual);
    if (actual !== expected)
    begin
      $display("MISMATCH %s mem_addr expected %h actual %h", test, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic compare_slot(string test, string which, fetch_slot_t expected,
                              fetch_slot_t actual);
    if (actual !== expected)
    begin
      $display("MISMATCH %s %s expected %h actual %h", test, which, expected, actual);
      stop_with_failure();
    end
  endtask

  // mid cycle check that hands the expected slots back for the model step
  task automatic check_outputs(input string test, output fetch_slot_t e0, output fetch_slot_t e1);
    logic busy;
    busy = stall || !mem_ready || reset;
    expect_slots(mem_data, busy, e0, e1);
    compare_addr(test, {model_pc[pc_width-1:3], 3'b000}, mem_addr);
    compare_slot(test, "slot0", e0, slot0);
    compare_slot(test, "slot1", e1, slot1);
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  task automatic add_row(string name, logic st, logic rdy, res_kind_t kind, pc_t bpc,
                         pc_t tgt, pht_index_t idx);
    row_t r;
    r.stall  = st;
    r.ready  = rdy;
    r.kind   = kind;
    r.pc     = bpc;
    r.target = tgt;
    r.index  = idx;
    rows.push_back(r);
    names.push_back(name);
  endtask

  function automatic resolve_t make_resolve(row_t r);
    resolve_t res;
    res = '0;
    if (r.kind != res_none)
    begin
      res.valid      = 1'b1;
      res.pc         = r.pc;
      res.taken      = (r.kind != res_not_taken_miss);
      res.target     = r.target;
      res.next_pc    = r.pc + 4;
      res.pht_index  = r.index;
      res.mispredict = (r.kind != res_taken_ok);
    end
    return res;
  endfunction

  task automatic build_table();
    add_row("seq_000", 0, 1, res_none, '0, '0, '0);  // straight line from 0
    add_row("seq_008", 0, 1, res_none, '0, '0, '0);
    add_row("seq_010", 0, 1, res_none, '0, '0, '0);
    add_row("seq_018", 0, 1, res_none, '0, '0, '0);
    // train branch 0x40 while fetch is held
    // index 0x13 is 0x10 ^ history 0x03 at its later fetch
    add_row("stall_resolve", 1, 1, res_taken_ok, 32'h40, 32'h104, 8'h13);
    add_row("not_ready_resolve", 0, 0, res_taken_ok, 32'h40, 32'h104, 8'h13);
    add_row("stall_idle", 1, 0, res_none, '0, '0, '0);
    add_row("resume_020", 0, 1, res_none, '0, '0, '0);
    add_row("seq_028", 0, 1, res_none, '0, '0, '0);
    add_row("seq_030", 0, 1, res_none, '0, '0, '0);
    add_row("seq_038", 0, 1, res_none, '0, '0, '0);
    add_row("taken_slot0", 0, 1, res_none, '0, '0, '0);   // predicts 0x104 and kills slot 1
    add_row("land_104", 0, 1, res_none, '0, '0, '0);      // slot 0 of 0x100 aliases entry 0
    add_row("redirect_miss", 0, 1, res_taken_miss, 32'h88, 32'h204, 8'h21);
    add_row("land_204", 0, 1, res_none, '0, '0, '0);      // unaligned target
    // push counter 0x2d up then down
    // history ends at 0x3d
    add_row("retrain", 0, 1, res_taken_ok, 32'h40, 32'h104, 8'h2d);
    add_row("lower_counter", 0, 1, res_not_taken_miss, 32'h40, 32'h104, 8'h2d);
    add_row("back_to_branch", 0, 1, res_taken_miss, 32'h3c, 32'h40, 8'h11);
    add_row("not_taken_hit", 0, 1, res_none, '0, '0, '0);  // btb hits but the counter says no
    // 0x440 shares btb entry 0 with a taken counter behind it
    add_row("alias_redirect", 0, 1, res_taken_miss, 32'h4c, 32'h440, 8'h6b);
    add_row("alias_miss", 0, 1, res_none, '0, '0, '0);
    add_row("seq_448", 0, 1, res_none, '0, '0, '0);
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial
  begin
    fetch_slot_t exp0;
    fetch_slot_t exp1;
    word_t       word;
    clock      = 1'b0;
    reset      = 1'b1;
    stall      = 1'b0;
    mem_ready  = 1'b1;                      // only reset can drop the valids here
    mem_data   = '0;
    resolve    = '0;
    lfsr_state = 16'd77;
    reset_model();
    build_table();
    @(posedge clock);
    repeat (2)
    begin
      @(negedge clock);
      check_outputs("reset", exp0, exp1);  // both valids low in reset
      @(posedge clock);
    end
    #2;
    reset = 1'b0;                           // after the third edge
    foreach (rows[i])
    begin
      next_mem_word(word);
      stall     = rows[i].stall;
      mem_ready = rows[i].ready;
      mem_data  = word;
      resolve   = make_resolve(rows[i]);
      @(negedge clock);                     // outputs settled
      check_outputs(names[i], exp0, exp1);
      step_model(resolve, stall || !mem_ready, exp0, exp1);
      @(posedge clock);
      #2;
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== design/fetch_unit.sv ====
// fetch unit top level joining sequencer, target buffer and direction predictor
`default_nettype none

module fetch_unit
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  input  logic        mem_ready,
  input  word_t       mem_data,
  input  resolve_t    resolve,     // one cycle strobe per branch
  output pc_t         mem_addr,
  output fetch_slot_t slot0,
  output fetch_slot_t slot1
);

  pc_t         lookup_pc0;  // slot addresses to the tables
  pc_t         lookup_pc1;
  btb_lookup_t lookup0;
  btb_lookup_t lookup1;
  logic        taken0;
  logic        taken1;
  pht_index_t  index0;
  pht_index_t  index1;

  ////////////////////////////////////////
  // sequencer owns the pc
  ////////////////////////////////////////

  fetch_sequencer seq0 (
    .clock      (clock),
    .reset      (reset),
    .stall      (stall),
    .mem_ready  (mem_ready),
    .mem_data   (mem_data),
    .resolve    (resolve),
    .lookup0    (lookup0),
    .lookup1    (lookup1),
    .taken0     (taken0),
    .taken1     (taken1),
    .index0     (index0),
    .index1     (index1),
    .mem_addr   (mem_addr),
    .lookup_pc0 (lookup_pc0),
    .lookup_pc1 (lookup_pc1),
    .slot0      (slot0),
    .slot1      (slot1)
  );

  // both tables read in parallel off the same addresses
  target_buffer btb0 (
    .clock      (clock),
    .reset      (reset),
    .lookup_pc0 (lookup_pc0),
    .lookup_pc1 (lookup_pc1),
    .resolve    (resolve),
    .lookup0    (lookup0),
    .lookup1    (lookup1)
  );

  direction_predictor bp0 (
    .clock      (clock),
    .reset      (reset),
    .lookup_pc0 (lookup_pc0),
    .lookup_pc1 (lookup_pc1),
    .resolve    (resolve),
    .taken0     (taken0),
    .taken1     (taken1),
    .index0     (index0),
    .index1     (index1)
  );

endmodule

`default_nettype wire

// ==== design/fetch_sequencer.sv ====
// fetch sequencer with pc register, slot build, prediction merge and next pc select
`default_nettype none

module fetch_sequencer
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        stall,
  input  logic        mem_ready,
  input  word_t       mem_data,    // same cycle as mem_addr
  input  resolve_t    resolve,
  input  btb_lookup_t lookup0,
  input  btb_lookup_t lookup1,
  input  logic        taken0,
  input  logic        taken1,
  input  pht_index_t  index0,
  input  pht_index_t  index1,
  output pc_t         mem_addr,
  output pc_t         lookup_pc0,
  output pc_t         lookup_pc1,
  output fetch_slot_t slot0,
  output fetch_slot_t slot1
);

  pc_t  pc_q;        // pc being fetched
  pc_t  pc_d;
  pc_t  word_base;   // pc with low 3 bits cleared
  logic stalling;
  logic redirect;
  logic kill1;       // taken branch in slot 0

  ////////////////////////////////////////
  // addresses
  ////////////////////////////////////////

  assign word_base  = {pc_q[pc_width-1:3], 3'b000};
  assign mem_addr   = word_base;
  assign lookup_pc0 = word_base;
  assign lookup_pc1 = {pc_q[pc_width-1:3], 3'b100};

  assign stalling = stall || !mem_ready;             // memory not there or pipe full
  assign redirect = resolve.valid && resolve.mispredict;

  ////////////////////////////////////////
  // slots
  ////////////////////////////////////////

  always_comb
  begin
    // low half of the word is slot 0
    slot0.pc         = lookup_pc0;
    slot0.inst       = mem_data[inst_width-1:0];
    slot0.next_pc    = lookup_pc0 + pc_t'(4);
    slot0.pred_taken = lookup0.hit && taken0;     // needs btb hit and counter
    slot0.pred_pc    = slot0.pred_taken ? lookup0.target : slot0.next_pc;
    slot0.pht_index  = index0;
    slot0.valid      = !pc_q[2] && !stalling && !reset;  // skipped on odd entry

    kill1 = slot0.valid && slot0.pred_taken;

    // high half
    slot1.pc         = lookup_pc1;
    slot1.inst       = mem_data[word_width-1:inst_width];
    slot1.next_pc    = lookup_pc1 + pc_t'(4);
    slot1.pred_taken = lookup1.hit && taken1;
    slot1.pred_pc    = slot1.pred_taken ? lookup1.target : slot1.next_pc;
    slot1.pht_index  = index1;
    slot1.valid      = !kill1 && !stalling && !reset;
  end

  ////////////////////////////////////////
  // next pc
  ////////////////////////////////////////

  always_comb
  begin
    if (redirect)
      pc_d = resolve.taken ? resolve.target : resolve.next_pc;  // wins over stall
    else if (stalling)
      pc_d = pc_q;
    else if (kill1)
      pc_d = slot0.pred_pc;
    else if (slot1.valid && slot1.pred_taken)
      pc_d = slot1.pred_pc;
    else
      pc_d = word_base + pc_t'(8);  // next aligned word
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      pc_q <= '0;     // boot at 0
    else
      pc_q <= pc_d;
  end

endmodule

`default_nettype wire

// ==== design/direction_predictor.sv ====
// gshare direction predictor with 2-bit counter table and global history register
`default_nettype none

module direction_predictor
  import fetch_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  pc_t        lookup_pc0,
  input  pc_t        lookup_pc1,
  input  resolve_t   resolve,
  output logic       taken0,      // slot 0 direction
  output logic       taken1,      // slot 1 direction
  output pht_index_t index0,
  output pht_index_t index1
);

  counter_t   pht_q [pht_entries];  // pattern history table
  pht_index_t history_q;            // non speculative ghr
  counter_t   step_value;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // gshare hash of word address and history
  function automatic pht_index_t hash(pc_t pc, pht_index_t hist);
    return pc[hist_bits+1:2] ^ hist;
  endfunction

  // saturating step up or down
  function automatic counter_t step(counter_t count, logic up);
    counter_t result;
    result = count;
    if (up)
    begin
      if (count != '1)
        result = count + 2'd1;
    end
    else
    begin
      if (count != '0)
        result = count - 2'd1;
    end
    return result;
  endfunction

  ////////////////////////////////////////
  // lookups
  ////////////////////////////////////////

  assign index0 = hash(lookup_pc0, history_q);
  assign index1 = hash(lookup_pc1, history_q);

  // same as the counter's upper bit
  assign taken0 = (pht_q[index0] >= counter_taken_min);
  assign taken1 = (pht_q[index1] >= counter_taken_min);

  ////////////////////////////////////////
  // resolve update
  ////////////////////////////////////////

  // index comes back with the branch, not rehashed
  assign step_value = step(pht_q[resolve.pht_index], resolve.taken);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < pht_entries; i++)
        pht_q[i] <= counter_reset;  // weakly not taken
    end
    else if (resolve.valid)
    begin
      pht_q[resolve.pht_index] <= step_value;
    end
  end

  // history shifts only on resolve
  always_ff @(posedge clock)
  begin
    if (reset)
      history_q <= '0;
    else if (resolve.valid)
      history_q <= {history_q[hist_bits-2:0], resolve.taken};  // newest in lsb
  end

endmodule

`default_nettype wire

// ==== design/target_buffer.sv ====
// direct-mapped branch target buffer with two lookup ports and one resolve write port
`default_nettype none

module target_buffer
  import fetch_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  pc_t         lookup_pc0,  // slot 0 address
  input  pc_t         lookup_pc1,  // slot 1 address
  input  resolve_t    resolve,
  output btb_lookup_t lookup0,
  output btb_lookup_t lookup1
);

  // tag and target of one entry
  typedef struct packed {
    btb_tag_t tag;
    pc_t      target;
  } btb_entry_t;

  logic [btb_entries-1:0] valid_q;             // one bit per entry
  btb_entry_t             entry_q [btb_entries];

  btb_index_t wr_index;
  btb_tag_t   wr_tag;
  logic       wr_en;

  ////////////////////////////////////////
  // address split helpers
  ////////////////////////////////////////

  // index sits right above the byte offset
  function automatic btb_index_t index_of(pc_t pc);
    return pc[btb_index_bits+1:2];
  endfunction

  // everything above the index
  function automatic btb_tag_t tag_of(pc_t pc);
    return pc[pc_width-1:btb_index_bits+2];
  endfunction

  // read one port against current state
  function automatic btb_lookup_t read_port(pc_t pc);
    btb_lookup_t result;
    btb_index_t  idx;
    idx           = index_of(pc);
    result.hit    = valid_q[idx] && (entry_q[idx].tag == tag_of(pc));
    result.target = entry_q[idx].target;
    return result;
  endfunction

  ////////////////////////////////////////
  // lookups
  ////////////////////////////////////////

  // both ports see the state before this cycle's write
  assign lookup0 = read_port(lookup_pc0);
  assign lookup1 = read_port(lookup_pc1);

  ////////////////////////////////////////
  // resolve write
  ////////////////////////////////////////

  assign wr_en    = resolve.valid && resolve.taken;  // not taken leaves entry alone
  assign wr_index = index_of(resolve.pc);
  assign wr_tag   = tag_of(resolve.pc);

  // valid bits
  always_ff @(posedge clock)
  begin
    if (reset)
      valid_q <= '0;
    else if (wr_en)
      valid_q[wr_index] <= 1'b1;
  end

  // newest taken branch overwrites tag and target
  always_ff @(posedge clock)
  begin
    if (wr_en)
    begin
      entry_q[wr_index].tag    <= wr_tag;
      entry_q[wr_index].target <= resolve.target;
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
// fetch front end package with widths, table sizes, counter encodings and shared structs
`default_nettype none

package fetch_pkg;

  ////////////////////////////////////////
  // widths and table sizes
  ////////////////////////////////////////
  localparam int pc_width       = 32;
  localparam int inst_width     = 32;
  localparam int word_width     = 2 * inst_width;        // one aligned fetch word
  localparam int hist_bits      = 8;                     // ghr length and pht index width
  localparam int pht_entries    = 2 ** hist_bits;
  localparam int btb_index_bits = 4;
  localparam int btb_entries    = 2 ** btb_index_bits;   // 16 entries
  localparam int btb_tag_bits   = pc_width - btb_index_bits - 2;

  typedef logic [pc_width-1:0]       pc_t;
  typedef logic [inst_width-1:0]     inst_t;
  typedef logic [word_width-1:0]     word_t;
  typedef logic [hist_bits-1:0]      pht_index_t;
  typedef logic [btb_index_bits-1:0] btb_index_t;
  typedef logic [btb_tag_bits-1:0]   btb_tag_t;

  // 2-bit saturating counter
  typedef logic [1:0] counter_t;
  localparam counter_t counter_reset     = 2'd1;  // weakly not taken
  localparam counter_t counter_taken_min = 2'd2;  // taken from here up

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  // one fetched instruction with its prediction
  typedef struct packed {
    logic       valid;
    pc_t        pc;         // own address
    inst_t      inst;
    pc_t        next_pc;    // pc + 4
    logic       pred_taken;
    pc_t        pred_pc;    // predicted successor
    pht_index_t pht_index;  // handed back at resolve
  } fetch_slot_t;

  // branch resolution strobe
  typedef struct packed {
    logic       valid;
    pc_t        pc;         // pc of the branch
    logic       taken;
    pc_t        target;
    pc_t        next_pc;    // fall through
    pht_index_t pht_index;
    logic       mispredict;
  } resolve_t;

  typedef struct packed {
    logic hit;
    pc_t  target;
  } btb_lookup_t;

endpackage

`default_nettype wire
